//--- include/fpir_cfg.svh
// FPIR datapath configuration
// Field widths, exponent bias and queue depth

`ifndef FPIR_CFG_SVH
`define FPIR_CFG_SVH

// Wide signed exponent, room for normalized subnormals
`define FPIR_BW_EXPONENT 10

// Significand including the hidden bit
`define FPIR_BW_SIGNIFICAND 24

// Bits below the significand
`define FPIR_BW_GUARD 2

// Bits above the exponent, sign and overflow of exponent math
`define FPIR_BW_OVERFLOW 2

// Encoded value class
`define FPIR_BW_TYPE 3

// Binary32 exponent bias
`define FPIR_BIAS 127

// Whole FPIR value: type, sign, exponent, significand, guard, overflow
`define FPIR_BW_VALUE (`FPIR_BW_TYPE + 1 + `FPIR_BW_EXPONENT + \
	`FPIR_BW_SIGNIFICAND + `FPIR_BW_GUARD + `FPIR_BW_OVERFLOW)

// Queue between issue stage and consumer, power of two
`define FPIR_FIFO_DEPTH 4

`endif

//--- rtl/fpir_fifo.sv
// FPIR request FIFO

`timescale 1ns/10ps

`include "fpir_cfg.svh"

module fpir_fifo
(
	input  logic                      clk,
	input  logic                      reset,
	// Write side
	input  logic                      wr_valid,
	output logic                      wr_ready,
	input  fpir_pkg::fpir_op_e        wr_op,
	input  logic [`FPIR_BW_VALUE-1:0] wr_a,
	input  logic [`FPIR_BW_VALUE-1:0] wr_b,
	// Read side, head entry
	output logic                      rd_valid,
	input  logic                      rd_ready,
	output fpir_pkg::fpir_op_e        rd_op,
	output logic [`FPIR_BW_VALUE-1:0] rd_a,
	output logic [`FPIR_BW_VALUE-1:0] rd_b
);

	import fpir_pkg::*;

	localparam int DEPTH = `FPIR_FIFO_DEPTH;
	localparam int BW_PTR = $clog2(DEPTH);
	localparam int BW_CNT = BW_PTR + 1;

	// Storage
	fpir_op_e                  op_mem [DEPTH];
	logic [`FPIR_BW_VALUE-1:0] a_mem  [DEPTH];
	logic [`FPIR_BW_VALUE-1:0] b_mem  [DEPTH];

	logic [BW_PTR-1:0] wr_ptr;
	logic [BW_PTR-1:0] rd_ptr;
	logic [BW_CNT-1:0] count;
	logic              push;
	logic              pop;

	// Full still takes a write when the head leaves in the same cycle
	assign wr_ready = (count != BW_CNT'(DEPTH)) || rd_ready;
	assign rd_valid = (count != '0);

	assign push = wr_valid && wr_ready;
	assign pop  = rd_valid && rd_ready;

	// Head is read straight from storage
	assign rd_op = op_mem[rd_ptr];
	assign rd_a  = a_mem[rd_ptr];
	assign rd_b  = b_mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			op_mem[wr_ptr] <= wr_op;
			a_mem[wr_ptr]  <= wr_a;
			b_mem[wr_ptr]  <= wr_b;
		end
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + BW_PTR'(1);
			if (pop)
				rd_ptr <= rd_ptr + BW_PTR'(1);
			if (push && !pop)
				count <= count + BW_CNT'(1);
			else if (pop && !push)
				count <= count - BW_CNT'(1);
		end
	end

endmodule

//--- rtl/fpir_issue.sv
// FPIR issue stage
// Unpacks and normalizes both operands

`timescale 1ns/10ps

`include "fpir_cfg.svh"

module fpir_issue
(
	input  logic                      clk,
	input  logic                      reset,
	// Request side
	input  logic                      in_valid,
	output logic                      in_ready,
	input  fpir_pkg::fpir_op_e        in_op,
	input  logic [31:0]               in_a,
	input  logic [31:0]               in_b,
	// Toward the FIFO
	output logic                      iss_valid,
	input  logic                      iss_ready,
	output fpir_pkg::fpir_op_e        iss_op,
	output logic [`FPIR_BW_VALUE-1:0] iss_a,
	output logic [`FPIR_BW_VALUE-1:0] iss_b
);

	logic                      in_accept;
	logic [`FPIR_BW_VALUE-1:0] raw_a;
	logic [`FPIR_BW_VALUE-1:0] raw_b;
	logic [`FPIR_BW_VALUE-1:0] norm_a;
	logic [`FPIR_BW_VALUE-1:0] norm_b;

	// ********************************************************
	// Operand conversion
	// ********************************************************

	fpir_unpack i_unpack_a
	(
		.word  (in_a),
		.value (raw_a)
	);

	fpir_unpack i_unpack_b
	(
		.word  (in_b),
		.value (raw_b)
	);

	// Subnormal significands get their hidden bit back
	fpir_normalizer i_norm_a
	(
		.value_in  (raw_a),
		.value_out (norm_a)
	);

	fpir_normalizer i_norm_b
	(
		.value_in  (raw_b),
		.value_out (norm_b)
	);

	// ********************************************************
	// Output register
	// ********************************************************

	// Closed in reset, then a free slot or the held entry leaves this cycle
	assign in_ready  = !reset && (!iss_valid || iss_ready);
	assign in_accept = in_valid && in_ready;

	always_ff @(posedge clk)
	begin
		if (reset)
			iss_valid <= 1'b0;
		else if (in_accept)
			iss_valid <= 1'b1;
		else if (iss_ready)
			iss_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (in_accept)
		begin
			iss_op <= in_op;
			iss_a  <= norm_a;
			iss_b  <= norm_b;
		end
	end

endmodule

//--- rtl/fpir_mul_pack.sv
// FPIR multiply and binary32 pack
// Consumer side with output register

`timescale 1ns/10ps

`include "fpir_cfg.svh"

module fpir_mul_pack
(
	input  logic                      clk,
	input  logic                      reset,
	// FIFO head
	input  logic                      head_valid,
	output logic                      head_ready,
	input  fpir_pkg::fpir_op_e        head_op,
	input  logic [`FPIR_BW_VALUE-1:0] head_a,
	input  logic [`FPIR_BW_VALUE-1:0] head_b,
	// Result side
	output logic                      out_valid,
	input  logic                      out_ready,
	output logic [31:0]               out_result
);

	import fpir_pkg::*;

	localparam int BW_SIG     = `FPIR_BW_SIGNIFICAND;
	localparam int BW_EXT_EXP = `FPIR_BW_OVERFLOW + `FPIR_BW_EXPONENT;
	localparam int BW_PROD    = 2 * BW_SIG;
	// Field positions, overflow bits at the bottom
	localparam int POS_SIG    = `FPIR_BW_OVERFLOW + `FPIR_BW_GUARD;
	localparam int POS_EXP    = POS_SIG + BW_SIG;
	localparam int POS_SIGN   = POS_EXP + `FPIR_BW_EXPONENT;
	localparam int POS_TYPE   = POS_SIGN + 1;
	localparam logic signed [BW_EXT_EXP-1:0] BIAS_EXT = `FPIR_BIAS;
	localparam logic [31:0] QNAN = 32'h7FC0_0000;

	logic [`FPIR_BW_TYPE-1:0]     a_type;
	logic [`FPIR_BW_TYPE-1:0]     b_type;
	logic                         a_sign;
	logic                         b_sign;
	logic signed [BW_EXT_EXP-1:0] a_exp;
	logic signed [BW_EXT_EXP-1:0] b_exp;
	logic [BW_SIG-1:0]            a_sig;
	logic [BW_SIG-1:0]            b_sig;

	logic a_nan;
	logic a_inf;
	logic a_zero;
	logic b_nan;
	logic b_inf;
	logic b_zero;

	logic [BW_PROD-1:0]           prod;
	logic                         prod_top;
	logic signed [BW_EXT_EXP-1:0] top_inc;
	logic signed [BW_EXT_EXP-1:0] mul_exp;
	logic [BW_SIG-2:0]            mul_man;
	logic                         mul_sign;
	logic [31:0]                  result;
	logic                         pop;

	// Flush below the smallest normal, saturate above the largest finite
	function automatic logic [31:0] pack_finite
	(
		input logic                         sign,
		input logic signed [BW_EXT_EXP-1:0] exp_unb,
		input logic [BW_SIG-2:0]            man
	);
		logic signed [BW_EXT_EXP-1:0] exp_biased;
		exp_biased = exp_unb + BIAS_EXT;
		if (exp_biased <= 0)
			return {sign, 31'd0};
		else if (exp_biased >= 255)
			return {sign, 8'hFF, 23'd0};
		else
			return {sign, exp_biased[7:0], man};
	endfunction

	// ********************************************************
	// Field extraction
	// ********************************************************

	assign a_type = head_a[POS_TYPE +: `FPIR_BW_TYPE];
	assign b_type = head_b[POS_TYPE +: `FPIR_BW_TYPE];
	assign a_sign = head_a[POS_SIGN];
	assign b_sign = head_b[POS_SIGN];
	assign a_exp  = $signed({head_a[`FPIR_BW_OVERFLOW-1:0], head_a[POS_EXP +: `FPIR_BW_EXPONENT]});
	assign b_exp  = $signed({head_b[`FPIR_BW_OVERFLOW-1:0], head_b[POS_EXP +: `FPIR_BW_EXPONENT]});
	assign a_sig  = head_a[POS_SIG +: BW_SIG];
	assign b_sig  = head_b[POS_SIG +: BW_SIG];

	assign a_nan  = (a_type == FPIR_TYPE_NAN);
	assign b_nan  = (b_type == FPIR_TYPE_NAN);
	assign a_inf  = (a_type == FPIR_TYPE_PINF) || (a_type == FPIR_TYPE_MINF);
	assign b_inf  = (b_type == FPIR_TYPE_PINF) || (b_type == FPIR_TYPE_MINF);
	assign a_zero = (a_type == FPIR_TYPE_PZERO) || (a_type == FPIR_TYPE_MZERO);
	assign b_zero = (b_type == FPIR_TYPE_PZERO) || (b_type == FPIR_TYPE_MZERO);

	// ********************************************************
	// Significand product
	// ********************************************************

	// Both inputs are normalized, so the product top sits in one of two bits
	assign prod     = a_sig * b_sig;
	assign prod_top = prod[BW_PROD-1];
	assign top_inc  = {{(BW_EXT_EXP-1){1'b0}}, prod_top};
	assign mul_exp  = a_exp + b_exp + top_inc;
	// Truncate below the kept mantissa
	assign mul_man  = prod_top ? prod[BW_PROD-2 -: BW_SIG-1] : prod[BW_PROD-3 -: BW_SIG-1];
	assign mul_sign = a_sign ^ b_sign;

	// Specials first, then the finite path
	always_comb
	begin
		if (head_op == FPIR_OP_CANON)
		begin
			if (a_nan)
				result = QNAN;
			else if (a_inf)
				result = {a_sign, 8'hFF, 23'd0};
			else if (a_zero)
				result = {a_sign, 31'd0};
			else
				result = pack_finite(a_sign, a_exp, a_sig[BW_SIG-2:0]);
		end
		else if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf))
			result = QNAN;
		else if (a_inf || b_inf)
			result = {mul_sign, 8'hFF, 23'd0};
		else if (a_zero || b_zero)
			result = {mul_sign, 31'd0};
		else
			result = pack_finite(mul_sign, mul_exp, mul_man);
	end

	// ********************************************************
	// Output register
	// ********************************************************

	assign head_ready = !out_valid || out_ready;
	assign pop        = head_valid && head_ready;

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid <= 1'b0;
		else if (pop)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (pop)
			out_result <= result;
	end

endmodule

//--- rtl/fpir_normalizer.sv
// FPIR significand normalizer

`timescale 1ns/10ps

`include "fpir_cfg.svh"

module fpir_normalizer
(
	input  logic [`FPIR_BW_VALUE-1:0] value_in,
	output logic [`FPIR_BW_VALUE-1:0] value_out
);

	import fpir_pkg::*;

	localparam int BW_EXT_EXP = `FPIR_BW_OVERFLOW + `FPIR_BW_EXPONENT;
	localparam int BW_EXT_SIG = `FPIR_BW_SIGNIFICAND + `FPIR_BW_GUARD;
	// Count range is 0 to BW_EXT_SIG inclusive
	localparam int BW_COUNT   = $clog2(BW_EXT_SIG + 1);

	// Incoming fields
	logic [`FPIR_BW_TYPE-1:0]        in_type;
	logic                            in_sign;
	logic [`FPIR_BW_EXPONENT-1:0]    in_exp;
	logic [`FPIR_BW_SIGNIFICAND-1:0] in_sig;
	logic [`FPIR_BW_GUARD-1:0]       in_guard;
	logic [`FPIR_BW_OVERFLOW-1:0]    in_ovf;

	// Working values
	logic signed [BW_EXT_EXP-1:0] exp_ext;
	logic signed [BW_EXT_EXP-1:0] exp_adj;
	logic [BW_EXT_SIG-1:0]        sig_ext;
	logic [BW_EXT_SIG-1:0]        sig_shift;
	logic [BW_COUNT-1:0]          lz_count;
	logic [BW_COUNT-1:0]          shift_amount;
	logic                         sig_zero;
	logic                         is_normal;
	logic [`FPIR_BW_TYPE-1:0]     out_type;

	assign {in_type, in_sign, in_exp, in_sig, in_guard, in_ovf} = value_in;

	// Overflow bits sit above the exponent
	assign exp_ext = $signed({in_ovf, in_exp});
	// Guard bits sit below the significand
	assign sig_ext = {in_sig, in_guard};

	assign is_normal = (in_type == FPIR_TYPE_NORMAL);
	assign sig_zero  = ~|sig_ext;

	// ********************************************************
	// Leading zero count
	// ********************************************************

	// Scan from the LSB so the highest set bit wins
	always_comb
	begin
		lz_count = BW_COUNT'(BW_EXT_SIG);
		for (int i = 0; i < BW_EXT_SIG; i++)
		begin
			if (sig_ext[i])
				lz_count = BW_COUNT'(BW_EXT_SIG - 1 - i);
		end
	end

	// Only a nonzero normal value is shifted
	assign shift_amount = (is_normal && !sig_zero) ? lz_count : '0;

	// ********************************************************
	// Shift and exponent adjust
	// ********************************************************

	assign sig_shift = sig_ext << shift_amount;
	assign exp_adj   = exp_ext - $signed({1'b0, shift_amount});

	// A normal value with nothing left becomes a signed zero
	always_comb
	begin
		if (is_normal && sig_zero)
		begin
			if (in_sign)
				out_type = FPIR_TYPE_MZERO;
			else
				out_type = FPIR_TYPE_PZERO;
		end
		else
			out_type = in_type;
	end

	assign value_out = {out_type, in_sign, exp_adj[`FPIR_BW_EXPONENT-1:0], sig_shift,
		exp_adj[BW_EXT_EXP-1:`FPIR_BW_EXPONENT]};

endmodule

//--- rtl/fpir_pkg.sv
// FPIR shared types

`include "fpir_cfg.svh"

package fpir_pkg;

	// ********************************************************
	// Value classes
	// ********************************************************

	// Class of an FPIR value
	// Subnormal encodings count as normal until normalized
	typedef enum logic [`FPIR_BW_TYPE-1:0]
	{
		// Finite nonzero value
		FPIR_TYPE_NORMAL = 3'd0,
		// Positive zero
		FPIR_TYPE_PZERO  = 3'd1,
		// Negative zero
		FPIR_TYPE_MZERO  = 3'd2,
		// Positive infinity
		FPIR_TYPE_PINF   = 3'd3,
		// Negative infinity
		FPIR_TYPE_MINF   = 3'd4,
		// Any NaN, quiet or signaling
		FPIR_TYPE_NAN    = 3'd5
	} fpir_type_e;

	// ********************************************************
	// Request opcodes
	// ********************************************************

	typedef enum logic [0:0]
	{
		// Product of a and b
		FPIR_OP_MUL   = 1'b0,
		// Operand a in canonical form
		FPIR_OP_CANON = 1'b1
	} fpir_op_e;

endpackage

//--- rtl/fpir_top.sv
// FPIR datapath top level

`timescale 1ns/10ps

`include "fpir_cfg.svh"

module fpir_top
(
	input  logic               clk,
	input  logic               reset,
	// Requests
	input  logic               in_valid,
	output logic               in_ready,
	input  fpir_pkg::fpir_op_e in_op,
	input  logic [31:0]        in_a,
	input  logic [31:0]        in_b,
	// Results
	output logic               out_valid,
	input  logic               out_ready,
	output logic [31:0]        out_result
);

	import fpir_pkg::*;

	// Issue stage to FIFO
	logic                      iss_valid;
	logic                      iss_ready;
	fpir_op_e                  iss_op;
	logic [`FPIR_BW_VALUE-1:0] iss_a;
	logic [`FPIR_BW_VALUE-1:0] iss_b;

	// FIFO head to consumer
	logic                      head_valid;
	logic                      head_ready;
	fpir_op_e                  head_op;
	logic [`FPIR_BW_VALUE-1:0] head_a;
	logic [`FPIR_BW_VALUE-1:0] head_b;

	fpir_issue i_issue
	(
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_op     (in_op),
		.in_a      (in_a),
		.in_b      (in_b),
		.iss_valid (iss_valid),
		.iss_ready (iss_ready),
		.iss_op    (iss_op),
		.iss_a     (iss_a),
		.iss_b     (iss_b)
	);

	// Absorbs output back-pressure before it reaches the requester
	fpir_fifo i_fifo
	(
		.clk      (clk),
		.reset    (reset),
		.wr_valid (iss_valid),
		.wr_ready (iss_ready),
		.wr_op    (iss_op),
		.wr_a     (iss_a),
		.wr_b     (iss_b),
		.rd_valid (head_valid),
		.rd_ready (head_ready),
		.rd_op    (head_op),
		.rd_a     (head_a),
		.rd_b     (head_b)
	);

	fpir_mul_pack i_mul_pack
	(
		.clk        (clk),
		.reset      (reset),
		.head_valid (head_valid),
		.head_ready (head_ready),
		.head_op    (head_op),
		.head_a     (head_a),
		.head_b     (head_b),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result)
	);

endmodule

//--- rtl/fpir_unpack.sv
// Binary32 to FPIR unpacker

`timescale 1ns/10ps

`include "fpir_cfg.svh"

module fpir_unpack
(
	input  logic [31:0]               word,
	output logic [`FPIR_BW_VALUE-1:0] value
);

	import fpir_pkg::*;

	// Exponent together with its overflow bits
	localparam int BW_EXT_EXP = `FPIR_BW_OVERFLOW + `FPIR_BW_EXPONENT;
	localparam logic signed [BW_EXT_EXP-1:0] BIAS_EXT = `FPIR_BIAS;

	// Raw binary32 fields
	logic        word_sign;
	logic [7:0]  word_exp;
	logic [22:0] word_man;

	logic exp_zero;
	logic exp_ones;
	logic man_zero;

	// Subnormals use the minimum normal exponent
	logic [7:0] exp_eff;

	fpir_type_e                      val_type;
	logic signed [BW_EXT_EXP-1:0]    val_exp_ext;
	logic [`FPIR_BW_SIGNIFICAND-1:0] val_sig;

	assign word_sign = word[31];
	assign word_exp  = word[30:23];
	assign word_man  = word[22:0];

	assign exp_zero = (word_exp == 8'h00);
	assign exp_ones = (word_exp == 8'hFF);
	assign man_zero = (word_man == 23'd0);

	// Classify the encoding
	always_comb
	begin
		if (exp_ones && !man_zero)
			val_type = FPIR_TYPE_NAN;
		else if (exp_ones && word_sign)
			val_type = FPIR_TYPE_MINF;
		else if (exp_ones)
			val_type = FPIR_TYPE_PINF;
		else if (exp_zero && man_zero && word_sign)
			val_type = FPIR_TYPE_MZERO;
		else if (exp_zero && man_zero)
			val_type = FPIR_TYPE_PZERO;
		else
			val_type = FPIR_TYPE_NORMAL;
	end

	// Hidden bit only on normal encodings
	assign val_sig = {!exp_zero && !exp_ones, word_man};

	// Unbiased exponent, sign extended into the overflow bits
	assign exp_eff     = exp_zero ? 8'd1 : word_exp;
	assign val_exp_ext = $signed({{(BW_EXT_EXP-8){1'b0}}, exp_eff}) - BIAS_EXT;

	assign value = {val_type, word_sign, val_exp_ext[`FPIR_BW_EXPONENT-1:0], val_sig,
		{`FPIR_BW_GUARD{1'b0}}, val_exp_ext[BW_EXT_EXP-1:`FPIR_BW_EXPONENT]};

endmodule

//--- tests/fpir_ref_model.svh
// Testbench reference model
// Random source and binary32 result rules

`ifndef FPIR_REF_MODEL_SVH
`define FPIR_REF_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'd76;
// Taps of x^32 + x^22 + x^2 + x + 1, right shifting form
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
localparam logic [31:0] CANON_NAN = 32'h7FC0_0000;

// One Galois step, the bit shifted out folds the taps back in
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	if (state[0])
		return (state >> 1) ^ LFSR_TAPS;
	else
		return state >> 1;
endfunction

function automatic logic is_nan32(input logic [31:0] w);
	return (w[30:23] == 8'hFF) && (w[22:0] != 23'd0);
endfunction

function automatic logic is_inf32(input logic [31:0] w);
	return (w[30:23] == 8'hFF) && (w[22:0] == 23'd0);
endfunction

function automatic logic is_zero32(input logic [31:0] w);
	return (w[30:0] == 31'd0);
endfunction

// Significand with its leading one at bit 23, nonzero finite input only
function automatic logic [23:0] finite_significand(input logic [31:0] w);
	logic [23:0] s;
	s = {(w[30:23] != 8'h00), w[22:0]};
	while (!s[23])
		s = s << 1;
	return s;
endfunction

// Unbiased exponent that goes with finite_significand
function automatic int finite_exponent(input logic [31:0] w);
	int          e;
	logic [23:0] s;
	e = (w[30:23] == 8'h00) ? -126 : int'(w[30:23]) - 127;
	s = {(w[30:23] != 8'h00), w[22:0]};
	// Subnormal: one exponent step per shift
	while (!s[23])
	begin
		s = s << 1;
		e = e - 1;
	end
	return e;
endfunction

// Below the smallest normal is zero, above the largest finite is infinity
function automatic logic [31:0] clamp_pack(input logic sign, input int e, input logic [22:0] man);
	int biased;
	biased = e + 127;
	if (biased <= 0)
		return {sign, 31'd0};
	else if (biased >= 255)
		return {sign, 8'hFF, 23'd0};
	else
		return {sign, biased[7:0], man};
endfunction

function automatic logic [31:0] expected_result(input fpir_op_e op, input logic [31:0] a,
	input logic [31:0] b);
	logic        sign;
	int          e;
	logic [47:0] p;
	logic [22:0] man;
	sign = a[31] ^ b[31];
	if (op == FPIR_OP_CANON)
	begin
		if (is_nan32(a))
			return CANON_NAN;
		// Subnormal and zero both give a signed zero
		if (a[30:23] == 8'h00)
			return {a[31], 31'd0};
		return a;
	end
	if (is_nan32(a) || is_nan32(b))
		return CANON_NAN;
	if ((is_inf32(a) && is_zero32(b)) || (is_zero32(a) && is_inf32(b)))
		return CANON_NAN;
	if (is_inf32(a) || is_inf32(b))
		return {sign, 8'hFF, 23'd0};
	if (is_zero32(a) || is_zero32(b))
		return {sign, 31'd0};
	p = finite_significand(a) * finite_significand(b);
	e = finite_exponent(a) + finite_exponent(b);
	// Product lies in [1,4), truncate toward zero
	if (p[47])
	begin
		e = e + 1;
		man = p[46:24];
	end
	else
		man = p[45:23];
	return clamp_pack(sign, e, man);
endfunction

`endif

//--- tests/tb_fpir_top.sv
// FPIR datapath testbench

`timescale 1ns/10ps

module tb_fpir_top;

	import fpir_pkg::*;

	`include "fpir_ref_model.svh"

	localparam int NUM_REQ = 400;
	// Twenty cycles per request plus reset and drain
	localparam int WATCHDOG_CYCLES = NUM_REQ * 20 + 200;

	logic        clk;
	logic        reset;
	logic        in_valid;
	logic        in_ready;
	fpir_op_e    in_op;
	logic [31:0] in_a;
	logic [31:0] in_b;
	logic        out_valid;
	logic        out_ready;
	logic [31:0] out_result;

	logic [31:0] lfsr_state;
	logic [31:0] expected_q [$];
	int          issued;
	int          received;
	int          stall_left;
	logic        req_taken;

	fpir_top i_dut
	(
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_op      (in_op),
		.in_a       (in_a),
		.in_b       (in_b),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result)
	);

	always #5 clk = ~clk;

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped on first error");
	endtask

	// Shift n LFSR bits into the low end of bits
	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
	endtask

	// ********************************************************
	// Operand mix
	// ********************************************************

	// Normals 5/8, subnormals 2/8, specials 1/8
	task automatic make_operand(output logic [31:0] word);
		logic [31:0] kind;
		logic [31:0] sign;
		logic [31:0] expo;
		logic [31:0] man;
		logic [31:0] pick;
		take_bits(3, kind);
		take_bits(1, sign);
		take_bits(23, man);
		case (kind[2:0])
			3'd4, 3'd5:
			begin
				// Random run of leading zeros for the normalizer
				take_bits(5, pick);
				man = man >> pick[4:0];
				if (man[22:0] == 23'd0)
					man = 32'd1;
				expo = 32'd0;
			end
			3'd6:
			begin
				take_bits(2, pick);
				expo = 32'd255;
				case (pick[1:0])
					2'd0:
					begin
						expo = 32'd0;
						man  = 32'd0;
					end
					2'd1: man = 32'd0;
					// Signaling NaN
					2'd2:
					begin
						man[22] = 1'b0;
						man[0]  = 1'b1;
					end
					default: man[22] = 1'b1;
				endcase
			end
			3'd3, 3'd7:
			begin
				// Whole range, products overflow and underflow often
				take_bits(8, expo);
				if (expo[7:0] == 8'h00)
					expo = 32'd1;
				else if (expo[7:0] == 8'hFF)
					expo = 32'd254;
			end
			default:
			begin
				// Near the bias, products mostly stay finite
				take_bits(6, expo);
				expo = expo + 32'd96;
			end
		endcase
		word = {sign[0], expo[7:0], man[22:0]};
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_with_error("Timeout, not all results arrived");
	end

	// ********************************************************
	// Stimulus and scoreboard
	// ********************************************************

	initial
	begin
		logic [31:0] pick;
		logic [31:0] exp_val;
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = FPIR_OP_MUL;
		in_a = 32'd0;
		in_b = 32'd0;
		out_ready = 1'b0;
		lfsr_state = LFSR_SEED;
		issued = 0;
		received = 0;
		stall_left = 0;
		req_taken = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		// Reset state, nothing taken and nothing offered
		assert (in_ready === 1'b0)
		else
			stop_with_error("in_ready is not low during reset");
		assert (out_valid === 1'b0)
		else
			stop_with_error("out_valid is not low during reset");
		reset = 1'b0;
		#1;
		assert (out_valid === 1'b0)
		else
			stop_with_error("out_valid is not low after reset");

		while (received < NUM_REQ)
		begin
			@(negedge clk);
			if (req_taken)
				in_valid = 1'b0;
			// Output stalls of up to 15 cycles fill the FIFO
			if (stall_left > 0)
			begin
				out_ready = 1'b0;
				stall_left--;
			end
			else
			begin
				take_bits(3, pick);
				if (pick[2:0] == 3'd0)
				begin
					take_bits(4, pick);
					stall_left = int'(pick[3:0]);
				end
				out_ready = 1'b1;
			end
			// New request only once the last one was taken
			if (!in_valid && issued < NUM_REQ)
			begin
				take_bits(2, pick);
				if (pick[1:0] != 2'd0)
				begin
					take_bits(2, pick);
					in_op = (pick[1:0] == 2'd0) ? FPIR_OP_CANON : FPIR_OP_MUL;
					make_operand(in_a);
					make_operand(in_b);
					in_valid = 1'b1;
				end
			end
			#1;
			// Both handshakes complete on the coming rising edge
			req_taken = in_valid && in_ready;
			if (req_taken)
			begin
				expected_q.push_back(expected_result(in_op, in_a, in_b));
				issued++;
			end
			if (out_valid && out_ready)
			begin
				assert (expected_q.size() > 0)
				else
					stop_with_error("Result delivered with no request outstanding");
				exp_val = expected_q.pop_front();
				assert (out_result === exp_val)
				else
					stop_with_error($sformatf("MISMATCH out_result got %08h expected %08h",
						out_result, exp_val));
				received++;
			end
		end

		// Count anything that still comes out
		repeat (20)
		begin
			@(negedge clk);
			out_ready = 1'b1;
			if (out_valid)
				received++;
		end
		assert (received == issued && expected_q.size() == 0)
		else
			stop_with_error($sformatf("Request count %0d and result count %0d do not match",
				issued, received));
		$display("** PASS **");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+include
+incdir+tests
rtl/fpir_pkg.sv
rtl/fpir_unpack.sv
rtl/fpir_normalizer.sv
rtl/fpir_issue.sv
rtl/fpir_fifo.sv
rtl/fpir_mul_pack.sv
rtl/fpir_top.sv
tests/tb_fpir_top.sv
